// File: Bender.yml
package:
  name: rv32_core

sources:
  - hdl/rv32_pkg.sv
  - hdl/decode_unit.sv
  - hdl/reg_file.sv
  - hdl/alu.sv
  - hdl/branch_resolve.sv
  - hdl/load_store_lane.sv
  - hdl/execute_stage.sv
  - hdl/fetch_stage.sv
  - hdl/rv32_core_top.sv
  - target: test
    files:
      - test/tb_bus_memories.sv
      - test/tb_rv32_core_top.sv

// File: filelist.f
hdl/rv32_pkg.sv
hdl/decode_unit.sv
hdl/reg_file.sv
hdl/alu.sv
hdl/branch_resolve.sv
hdl/load_store_lane.sv
hdl/execute_stage.sv
hdl/fetch_stage.sv
hdl/rv32_core_top.sv
test/tb_bus_memories.sv
test/tb_rv32_core_top.sv

// File: hdl/alu.sv
// -----------------------------------------------
// RV32I ALU, purely combinational.
// Shifts use port_b[4:0]; compares give 0 or 1.
// -----------------------------------------------
module alu import rv32_pkg::*; (
    input  alu_op_t alu_op,
    input  word_t   port_a,
    input  word_t   port_b,
    output word_t   port_out
);

    logic [4:0] shamt;

    assign shamt = port_b[4:0];

    always_comb begin
        case (alu_op)
            ALU_ADD:  port_out = port_a + port_b;
            ALU_SUB:  port_out = port_a - port_b;
            ALU_SLL:  port_out = port_a << shamt;
            ALU_SLT:  port_out = {31'b0, $signed(port_a) < $signed(port_b)};
            ALU_SLTU: port_out = {31'b0, port_a < port_b};
            ALU_XOR:  port_out = port_a ^ port_b;
            ALU_SRL:  port_out = port_a >> shamt;
            // Arithmetic shift keeps the sign bit
            ALU_SRA:  port_out = word_t'($signed(port_a) >>> shamt);
            ALU_OR:   port_out = port_a | port_b;
            ALU_AND:  port_out = port_a & port_b;
            default:  port_out = '0;
        endcase
    end

endmodule

// File: hdl/branch_resolve.sv
// -----------------------------------------------
// Conditional branch test and target.
// taken is only meaningful for branch opcodes.
// -----------------------------------------------
module branch_resolve import rv32_pkg::*; (
    input  branch_t branch_type,
    input  word_t   rs1_data,
    input  word_t   rs2_data,
    input  word_t   pc,
    input  word_t   imm_b,
    output logic    taken,
    output word_t   target
);

    always_comb begin
        case (branch_type)
            BEQ:     taken = (rs1_data == rs2_data);
            BNE:     taken = (rs1_data != rs2_data);
            BLT:     taken = ($signed(rs1_data) < $signed(rs2_data));
            BGE:     taken = ($signed(rs1_data) >= $signed(rs2_data));
            BLTU:    taken = (rs1_data < rs2_data);
            BGEU:    taken = (rs1_data >= rs2_data);
            default: taken = 1'b0;
        endcase
    end

    assign target = pc + imm_b;

endmodule

// File: hdl/decode_unit.sv
// -----------------------------------------------
// Combinational RV32I decoder.
// Unknown opcodes, FENCE and EBREAK decode as
// no-ops. Only an all-zero SYSTEM word is ECALL.
// Immediates are sign-extended to 32 bits.
// -----------------------------------------------
module decode_unit import rv32_pkg::*; (
    input  word_t      instr,
    output logic [4:0] rs1,
    output logic [4:0] rs2,
    output logic [4:0] rd,
    output alu_op_t    alu_op,
    output a_sel_t     a_sel,
    output b_sel_t     b_sel,
    output w_sel_t     w_sel,
    output load_t      load_type,
    output branch_t    branch_type,
    output word_t      imm_i,
    output word_t      imm_s,
    output word_t      imm_b,
    output word_t      imm_u,
    output word_t      imm_j,
    output logic       reg_wen,
    output logic       dren,
    output logic       dwen,
    output logic       is_branch,
    output logic       is_jal,
    output logic       is_jalr,
    output logic       is_ecall
);

    logic [2:0] funct3;

    // funct3 plus the instr[30] modifier select the ALU operation
    function automatic alu_op_t arith_op(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    assign funct3      = instr[14:12];
    assign rs1         = instr[19:15];
    assign rs2         = instr[24:20];
    assign rd          = instr[11:7];
    assign load_type   = load_t'(funct3);
    assign branch_type = branch_t'(funct3);

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        alu_op    = ALU_ADD;
        a_sel     = A_RS1;
        b_sel     = B_RS2;
        w_sel     = W_ALU;
        reg_wen   = 1'b0;
        dren      = 1'b0;
        dwen      = 1'b0;
        is_branch = 1'b0;
        is_jal    = 1'b0;
        is_jalr   = 1'b0;
        is_ecall  = 1'b0;
        case (opcode_t'(instr[6:0]))
            LUI: begin
                reg_wen = 1'b1;
                a_sel   = A_ZERO;
                b_sel   = B_IMM_U;
                w_sel   = W_IMM_U;
            end
            AUIPC: begin
                reg_wen = 1'b1;
                a_sel   = A_PC;
                b_sel   = B_IMM_U;
            end
            JAL: begin
                reg_wen = 1'b1;
                w_sel   = W_PC4;
                is_jal  = 1'b1;
            end
            JALR: begin
                reg_wen = 1'b1;
                w_sel   = W_PC4;
                is_jalr = 1'b1;
            end
            BRANCH: is_branch = 1'b1;
            LOAD: begin
                reg_wen = 1'b1;
                dren    = 1'b1;
                w_sel   = W_LOAD;
            end
            STORE: dwen = 1'b1;
            IMMED: begin
                reg_wen = 1'b1;
                b_sel   = B_IMM_I;
                // Only SRAI uses bit 30; ADDI keeps it as immediate
                alu_op  = arith_op(funct3, (funct3 == 3'b101) & instr[30]);
            end
            REGREG: begin
                reg_wen = 1'b1;
                alu_op  = arith_op(funct3, instr[30]);
            end
            SYSTEM: is_ecall = (instr[31:7] == '0);
            default: reg_wen = 1'b0;
        endcase
    end

endmodule

// File: hdl/execute_stage.sv
// -----------------------------------------------
// Execute stage: decode, register read, ALU,
// branch/jump, data bus access and writeback in
// one cycle. Loads/stores stall on dmem_busy.
// Misaligned accesses are dropped, no writeback.
// ECALL sets a sticky halt until reset.
// -----------------------------------------------
module execute_stage import rv32_pkg::*; #(
    parameter int NUM_REGS = 32
) (
    input  logic       CLK,
    input  logic       nRST,
    input  logic       fe_valid,
    input  word_t      fe_instr,
    input  word_t      fe_pc,
    output logic       fe_ready,
    output logic       redirect,
    output word_t      redirect_pc,
    output word_t      dmem_addr,
    output logic       dmem_ren,
    output logic       dmem_wen,
    output logic [3:0] dmem_byte_en,
    output word_t      dmem_wdata,
    input  word_t      dmem_rdata,
    input  logic       dmem_busy,
    output logic       halt,
    output logic       mal_access
);

    logic [4:0] rs1, rs2, rd;
    alu_op_t    alu_op;
    a_sel_t     a_sel;
    b_sel_t     b_sel;
    w_sel_t     w_sel;
    load_t      load_type;
    branch_t    branch_type;
    word_t      imm_i, imm_s, imm_b, imm_u, imm_j;
    logic       reg_wen, dren, dwen, is_branch, is_jal, is_jalr, is_ecall;
    word_t      rs1_data, rs2_data, w_data, port_a, port_b, alu_out;
    word_t      br_target, load_data, pc4;
    logic       taken, misaligned, active, mem_op, mem_req, fire;

    decode_unit i_decode (.instr(fe_instr), .*);

    reg_file #(.NUM_REGS(NUM_REGS)) i_reg_file (
        .CLK, .nRST, .rs1, .rs2, .rd,
        .wen(fire & reg_wen & ~(dren & misaligned)),
        .w_data, .rs1_data, .rs2_data
    );

    alu i_alu (.alu_op, .port_a, .port_b, .port_out(alu_out));

    branch_resolve i_branch (
        .branch_type, .rs1_data, .rs2_data, .pc(fe_pc), .imm_b,
        .taken, .target(br_target)
    );

    // Separate address adder, stores use the S immediate
    assign dmem_addr = rs1_data + (dwen ? imm_s : imm_i);

    load_store_lane i_lane (
        .load_type, .addr_low(dmem_addr[1:0]), .store_data(rs2_data),
        .bus_rdata(dmem_rdata), .byte_en(dmem_byte_en), .bus_wdata(dmem_wdata),
        .load_data, .misaligned
    );

    always_comb begin
        case (a_sel)
            A_PC:    port_a = fe_pc;
            A_ZERO:  port_a = '0;
            default: port_a = rs1_data;
        endcase
        case (b_sel)
            B_IMM_I: port_b = imm_i;
            B_IMM_U: port_b = imm_u;
            default: port_b = rs2_data;
        endcase
        case (w_sel)
            W_LOAD:  w_data = load_data;
            W_PC4:   w_data = pc4;
            W_IMM_U: w_data = imm_u;
            default: w_data = alu_out;
        endcase
    end

    assign pc4        = fe_pc + 32'd4;
    assign active     = fe_valid & ~halt;
    assign mem_op     = dren | dwen;
    assign mem_req    = active & mem_op & ~misaligned;
    assign dmem_ren   = mem_req & dren;
    assign dmem_wen   = mem_req & dwen;
    assign mal_access = active & mem_op & misaligned;

    // Memory ops finish in the cycle busy drops
    assign fe_ready = ~halt & ~(mem_req & dmem_busy);
    assign fire     = fe_valid & fe_ready;

    // Static not-taken, so only taken branches and jumps redirect
    assign redirect = fire & (is_jal | is_jalr | (is_branch & taken));
    always_comb begin
        if (is_jal) redirect_pc = fe_pc + imm_j;
        else if (is_jalr) redirect_pc = (rs1_data + imm_i) & ~32'd1;
        else redirect_pc = br_target;
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) halt <= 1'b0;
        else if (fire & is_ecall) halt <= 1'b1;
    end

endmodule

// File: hdl/fetch_stage.sv
// -----------------------------------------------
// PC register, instruction bus request and a
// one-entry holding register toward execute.
// redirect wins over a fetch completing in the
// same cycle. No requests in reset or once halt
// is high.
// -----------------------------------------------
module fetch_stage import rv32_pkg::*; (
    input  logic  CLK,
    input  logic  nRST,
    output word_t imem_addr,
    output logic  imem_ren,
    input  word_t imem_rdata,
    input  logic  imem_busy,
    output logic  fe_valid,
    output word_t fe_instr,
    output word_t fe_pc,
    input  logic  fe_ready,
    input  logic  redirect,
    input  word_t redirect_pc,
    input  logic  halt
);

    word_t pc;
    logic  capture;

    // Request while the holding register is free or being drained
    assign imem_ren  = nRST & ~halt & (~fe_valid | fe_ready);
    assign imem_addr = pc;
    assign capture   = imem_ren & ~imem_busy & ~redirect;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            pc       <= '0;
            fe_valid <= 1'b0;
        end else if (redirect) begin
            pc       <= redirect_pc;
            fe_valid <= 1'b0;
        end else if (capture) begin
            pc       <= pc + 32'd4;
            fe_valid <= 1'b1;
        end else if (fe_ready) begin
            fe_valid <= 1'b0;
        end
    end

    always_ff @(posedge CLK) begin
        if (capture) begin
            fe_instr <= imem_rdata;
            fe_pc    <= pc;
        end
    end

endmodule

// File: hdl/load_store_lane.sv
// -----------------------------------------------
// Data bus lane steering, little-endian lanes.
// Store sizes reuse the load funct3 encodings.
// Half at odd address or word at non-zero offset
// is flagged misaligned; byte_en is then 0.
// -----------------------------------------------
module load_store_lane import rv32_pkg::*; (
    input  load_t      load_type,
    input  logic [1:0] addr_low,
    input  word_t      store_data,
    input  word_t      bus_rdata,
    output logic [3:0] byte_en,
    output word_t      bus_wdata,
    output word_t      load_data,
    output logic       misaligned
);

    word_t lane_data;

    // Move the addressed lane down to bit 0
    assign lane_data = bus_rdata >> {addr_low, 3'b000};

    always_comb begin
        byte_en    = 4'b0000;
        misaligned = 1'b0;
        case (load_type)
            LB, LBU: byte_en = 4'b0001 << addr_low;
            LH, LHU: begin
                misaligned = addr_low[0];
                if (!addr_low[0]) begin
                    byte_en = addr_low[1] ? 4'b1100 : 4'b0011;
                end
            end
            LW: begin
                misaligned = (addr_low != 2'b00);
                if (addr_low == 2'b00) begin
                    byte_en = 4'b1111;
                end
            end
            default: byte_en = 4'b0000;
        endcase
    end

    // Replicate so every enabled lane carries the right bytes
    always_comb begin
        case (load_type)
            LB, LBU: bus_wdata = {4{store_data[7:0]}};
            LH, LHU: bus_wdata = {2{store_data[15:0]}};
            default: bus_wdata = store_data;
        endcase
    end

    always_comb begin
        case (load_type)
            LB:      load_data = {{24{lane_data[7]}}, lane_data[7:0]};
            LBU:     load_data = {24'b0, lane_data[7:0]};
            LH:      load_data = {{16{lane_data[15]}}, lane_data[15:0]};
            LHU:     load_data = {16'b0, lane_data[15:0]};
            default: load_data = bus_rdata;
        endcase
    end

endmodule

// File: hdl/reg_file.sv
// -----------------------------------------------
// Integer register file, 2 read / 1 write.
// NUM_REGS is 32 (RV32I) or 16 (RV32E). Indices
// at or above NUM_REGS read zero, ignore writes.
// Reads are combinational, writes on the edge.
// -----------------------------------------------
module reg_file import rv32_pkg::*; #(
    parameter int NUM_REGS = 32
) (
    input  logic       CLK,
    input  logic       nRST,
    input  logic [4:0] rs1,
    input  logic [4:0] rs2,
    input  logic [4:0] rd,
    input  logic       wen,
    input  word_t      w_data,
    output word_t      rs1_data,
    output word_t      rs2_data
);

    word_t regs [NUM_REGS];

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            regs <= '{default: '0};
        end else if (wen && rd != 5'd0 && rd < NUM_REGS) begin
            regs[rd] <= w_data;
        end
    end

    // x0 stays zero since it is never written
    assign rs1_data = (rs1 < NUM_REGS) ? regs[rs1] : '0;
    assign rs2_data = (rs2 < NUM_REGS) ? regs[rs2] : '0;

endmodule

// File: hdl/rv32_core_top.sv
// -----------------------------------------------
// Two-stage RV32I core, fetch and execute.
// NUM_REGS: 32 for RV32I, 16 for RV32E.
// Request/busy buses, both little-endian.
// -----------------------------------------------
module rv32_core_top import rv32_pkg::*; #(
    parameter int NUM_REGS = 32
) (
    input  logic       CLK,
    input  logic       nRST,
    output word_t      imem_addr,
    output logic       imem_ren,
    input  word_t      imem_rdata,
    input  logic       imem_busy,
    output word_t      dmem_addr,
    output logic       dmem_ren,
    output logic       dmem_wen,
    output logic [3:0] dmem_byte_en,
    output word_t      dmem_wdata,
    input  word_t      dmem_rdata,
    input  logic       dmem_busy,
    output logic       halt,
    output logic       mal_access
);

    logic  fe_valid, fe_ready, redirect;
    word_t fe_instr, fe_pc, redirect_pc;

    fetch_stage i_fetch (.*);

    execute_stage #(.NUM_REGS(NUM_REGS)) i_execute (.*);

endmodule

// File: hdl/rv32_pkg.sv
// -----------------------------------------------
// Shared types for the two-stage RV32I core.
// Enumeration values follow the RV32I opcode and
// funct3 encodings where one exists.
// Both buses are little-endian.
// -----------------------------------------------
package rv32_pkg;

    typedef logic [31:0] word_t;

    // Major opcodes, instr[6:0]
    typedef enum logic [6:0] {
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        BRANCH = 7'b1100011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        IMMED  = 7'b0010011,
        REGREG = 7'b0110011,
        SYSTEM = 7'b1110011
    } opcode_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
    } alu_op_t;

    // funct3 of loads; stores share the size bits
    typedef enum logic [2:0] {
        LB  = 3'b000,
        LH  = 3'b001,
        LW  = 3'b010,
        LBU = 3'b100,
        LHU = 3'b101
    } load_t;

    typedef enum logic [2:0] {
        BEQ  = 3'b000,
        BNE  = 3'b001,
        BLT  = 3'b100,
        BGE  = 3'b101,
        BLTU = 3'b110,
        BGEU = 3'b111
    } branch_t;

    typedef enum logic [1:0] {W_LOAD, W_PC4, W_IMM_U, W_ALU} w_sel_t;
    typedef enum logic [1:0] {A_RS1, A_PC, A_ZERO} a_sel_t;
    typedef enum logic [1:0] {B_RS2, B_IMM_I, B_IMM_U} b_sel_t;

endpackage

// File: test/tb_bus_memories.sv
// --------------------------------------------------
// Instruction and data memories for the core test.
// Holds the hand-assembled test program at PC 0.
// Busy is random every cycle, seeded 32'h28d1.
// Data memory is 256 words.
// Writes land on the falling edge.
// Read data is X while no read is requested.
// --------------------------------------------------
module tb_bus_memories import rv32_pkg::*; (
    input  logic        CLK,
    input  logic [31:0] imem_addr,
    input  logic        imem_ren,
    output logic [31:0] imem_rdata,
    output logic        imem_busy,
    input  logic [31:0] dmem_addr,
    input  logic        dmem_ren,
    input  logic        dmem_wen,
    input  logic [3:0]  dmem_byte_en,
    input  logic [31:0] dmem_wdata,
    output logic [31:0] dmem_rdata,
    output logic        dmem_busy
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [31:0] imem [128];
    logic [31:0] dmem [256];
    integer      seed;

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, REGREG};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], STORE};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], BRANCH};
    endfunction

    function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm, rd, op};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, JAL};
    endfunction

    task automatic load_program();
        // Branch f3 and operand registers for the taken and the not-taken case
        logic [2:0] f3s [6]   = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
        logic [4:0] t_rs1 [6] = '{5'd5, 5'd2, 5'd2, 5'd4, 5'd4, 5'd2};
        logic [4:0] t_rs2 [6] = '{5'd5, 5'd4, 5'd4, 5'd2, 5'd2, 5'd4};
        logic [4:0] n_rs1 [6] = '{5'd2, 5'd5, 5'd4, 5'd2, 5'd2, 5'd4};
        logic [4:0] n_rs2 [6] = '{5'd4, 5'd5, 5'd2, 5'd4, 5'd4, 5'd2};
        logic [31:0] skip;
        skip = enc_s(12'h080, 2, 1, 3'b010);
        imem[0]  = enc_i(12'h100, 0, 3'b000, 1, IMMED);
        imem[1]  = enc_u(20'h87654, 2, LUI);
        imem[2]  = enc_i(12'h321, 2, 3'b000, 2, IMMED);
        imem[3]  = enc_s(12'h000, 2, 1, 3'b010);
        imem[4]  = enc_i(12'h404, 2, 3'b101, 3, IMMED);
        imem[5]  = enc_s(12'h004, 3, 1, 3'b010);
        imem[6]  = enc_i(12'h008, 2, 3'b101, 3, IMMED);
        imem[7]  = enc_s(12'h008, 3, 1, 3'b010);
        imem[8]  = enc_r(7'h20, 2, 0, 3'b000, 4);
        imem[9]  = enc_r(7'h00, 2, 4, 3'b011, 5);
        imem[10] = enc_r(7'h00, 4, 2, 3'b010, 6);
        imem[11] = enc_i(12'h001, 6, 3'b001, 6, IMMED);
        imem[12] = enc_r(7'h00, 6, 5, 3'b110, 7);
        imem[13] = enc_r(7'h00, 4, 7, 3'b100, 7);
        imem[14] = enc_s(12'h00c, 7, 1, 3'b010);
        imem[15] = enc_u(20'h00001, 8, AUIPC);
        imem[16] = enc_r(7'h00, 4, 2, 3'b111, 9);
        imem[17] = enc_r(7'h00, 9, 8, 3'b000, 8);
        imem[18] = enc_s(12'h010, 8, 1, 3'b010);
        for (int k = 0; k < 6; k++) begin
            imem[19 + 2 * k] = enc_b(13'd8, t_rs2[k], t_rs1[k], f3s[k]);
            imem[20 + 2 * k] = skip;
            imem[31 + 2 * k] = enc_b(13'd8, n_rs2[k], n_rs1[k], f3s[k]);
            imem[32 + 2 * k] = enc_i(12'h001, 10, 3'b000, 10, IMMED);
        end
        imem[43] = enc_s(12'h014, 10, 1, 3'b010);
        imem[44] = enc_j(21'd8, 12);
        imem[45] = skip;
        imem[46] = enc_s(12'h018, 12, 1, 3'b010);
        imem[47] = enc_u(20'h00000, 14, AUIPC);
        // The JALR target drops bit 0 of the odd offset
        imem[48] = enc_i(12'd13, 14, 3'b000, 13, JALR);
        imem[49] = skip;
        imem[50] = enc_s(12'h01c, 13, 1, 3'b010);
        imem[51] = enc_s(12'h021, 2, 1, 3'b000);
        imem[52] = enc_s(12'h026, 2, 1, 3'b001);
        imem[53] = enc_i(12'h041, 1, 3'b000, 15, LOAD);
        imem[54] = enc_s(12'h030, 15, 1, 3'b010);
        imem[55] = enc_i(12'h043, 1, 3'b100, 16, LOAD);
        imem[56] = enc_s(12'h034, 16, 1, 3'b010);
        imem[57] = enc_i(12'h042, 1, 3'b001, 17, LOAD);
        imem[58] = enc_s(12'h038, 17, 1, 3'b010);
        imem[59] = enc_i(12'h040, 1, 3'b101, 18, LOAD);
        imem[60] = enc_s(12'h03c, 18, 1, 3'b010);
        imem[61] = enc_i(12'h040, 1, 3'b010, 19, LOAD);
        imem[62] = enc_s(12'h044, 19, 1, 3'b010);
        imem[63] = enc_i(12'h05a, 0, 3'b000, 20, IMMED);
        imem[64] = enc_i(12'h041, 1, 3'b010, 20, LOAD);
        imem[65] = enc_s(12'h043, 2, 1, 3'b001);
        imem[66] = enc_s(12'h048, 20, 1, 3'b010);
        imem[67] = 32'h0000_0073;
        imem[68] = skip;
    endtask

    initial begin
        seed      = 32'h28d1;
        imem_busy = 1'b0;
        dmem_busy = 1'b0;
        for (int i = 0; i < 128; i++) begin
            imem[i] = '0;
        end
        for (int i = 0; i < 256; i++) begin
            dmem[i] = 32'hd000_0000 | (i << 12) | i;
        end
        // Load source word at 0x140
        dmem[8'h50] = 32'h80f7_a155;
        load_program();
    end

    assign imem_rdata = imem_ren ? imem[imem_addr[8:2]] : 'x;
    assign dmem_rdata = dmem_ren ? dmem[dmem_addr[9:2]] : 'x;

    always @(posedge CLK) begin
        #1;
        imem_busy = (($random(seed) & 3) == 0);
        dmem_busy = $random(seed) & 1;
    end

    always @(negedge CLK) begin
        if (dmem_wen && !dmem_busy) begin
            for (int b = 0; b < 4; b++) begin
                if (dmem_byte_en[b]) begin
                    dmem[dmem_addr[9:2]][8 * b +: 8] = dmem_wdata[8 * b +: 8];
                end
            end
        end
    end

endmodule

// File: test/tb_rv32_core_top.sv
// --------------------------------------------------
// Testbench for the two-stage RV32I core.
// Completed stores are compared in order against a
// table of RV32I results. Outputs are sampled on
// the falling edge. Inputs change 1 ns after the
// rising edge.
// --------------------------------------------------
module tb_rv32_core_top;
    timeunit 1ns;
    timeprecision 1ps;

    logic        CLK, nRST;
    logic [31:0] imem_addr, imem_rdata, dmem_addr, dmem_wdata, dmem_rdata;
    logic        imem_ren, imem_busy, dmem_ren, dmem_wen, dmem_busy;
    logic [3:0]  dmem_byte_en;
    logic        halt, mal_access;

    int          errors, mal_count, store_count, cycles;
    logic        halt_seen, prev_dreq, prev_ireq;
    logic [69:0] prev_dbus;
    logic [32:0] prev_ibus;
    logic [31:0] exp_addr [$];
    logic [3:0]  exp_be [$];
    logic [31:0] exp_data [$];

    rv32_core_top #(.NUM_REGS(32)) i_dut (.*);

    tb_bus_memories i_mem (.*);

    always #4 CLK = ~CLK;

    task automatic expect_store(input logic [31:0] a, input logic [3:0] be,
                                input logic [31:0] d);
        exp_addr.push_back(a);
        exp_be.push_back(be);
        exp_data.push_back(d);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("Fail at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic load_expected();
        expect_store(32'h100, 4'hf, 32'h8765_4321);
        expect_store(32'h104, 4'hf, 32'hf876_5432);
        expect_store(32'h108, 4'hf, 32'h0087_6543);
        expect_store(32'h10c, 4'hf, 32'h789a_bcdc);
        expect_store(32'h110, 4'hf, 32'h0000_103d);
        // Six not-taken branches each fall into one increment
        expect_store(32'h114, 4'hf, 32'h0000_0006);
        expect_store(32'h118, 4'hf, 32'h0000_00b4);
        expect_store(32'h11c, 4'hf, 32'h0000_00c4);
        expect_store(32'h121, 4'b0010, 32'h2121_2121);
        expect_store(32'h126, 4'b1100, 32'h4321_4321);
        expect_store(32'h130, 4'hf, 32'hffff_ffa1);
        expect_store(32'h134, 4'hf, 32'h0000_0080);
        expect_store(32'h138, 4'hf, 32'hffff_80f7);
        expect_store(32'h13c, 4'hf, 32'h0000_a155);
        expect_store(32'h144, 4'hf, 32'h80f7_a155);
        // Misaligned load left x20 alone
        expect_store(32'h148, 4'hf, 32'h0000_005a);
    endtask

    always @(negedge CLK) begin
        if (nRST) begin
            if (dmem_wen && !dmem_busy) begin
                store_count++;
                if (exp_addr.size() == 0) begin
                    errors++;
                    $display("Unexpected store to %h at %0t", dmem_addr, $time);
                end else begin
                    check_value("dmem_addr", dmem_addr, exp_addr.pop_front());
                    check_value("dmem_byte_en", dmem_byte_en, exp_be.pop_front());
                    check_value("dmem_wdata", dmem_wdata, exp_data.pop_front());
                end
            end
            if (prev_dreq) begin
                assert ({dmem_ren, dmem_wen, dmem_addr, dmem_byte_en, dmem_wdata} === prev_dbus)
                else begin
                    errors++;
                    $display("Data request changed while busy at %0t", $time);
                end
            end
            if (prev_ireq && !halt) begin
                assert ({imem_ren, imem_addr} === prev_ibus) else begin
                    errors++;
                    $display("Instruction request changed while busy at %0t", $time);
                end
            end
            if (mal_access) begin
                mal_count++;
                assert (!dmem_ren && !dmem_wen) else begin
                    errors++;
                    $display("Misaligned access still made a bus request at %0t", $time);
                end
            end
            if (halt_seen) begin
                assert (halt) else begin
                    errors++;
                    $display("halt dropped after it was set at %0t", $time);
                end
            end
            if (halt) begin
                halt_seen = 1'b1;
                assert (!imem_ren && !dmem_wen) else begin
                    errors++;
                    $display("Bus activity after halt at %0t", $time);
                end
            end
        end else begin
            assert (!imem_ren && !dmem_ren && !dmem_wen && !halt && !mal_access) else begin
                errors++;
                $display("Bus request or status output high during reset at %0t", $time);
            end
        end
        prev_dreq = (dmem_ren || dmem_wen) && dmem_busy;
        prev_dbus = {dmem_ren, dmem_wen, dmem_addr, dmem_byte_en, dmem_wdata};
        prev_ireq = imem_ren && imem_busy && !i_dut.redirect;
        prev_ibus = {imem_ren, imem_addr};
    end

    initial begin
        errors      = 0;
        mal_count   = 0;
        store_count = 0;
        halt_seen   = 1'b0;
        prev_dreq   = 1'b0;
        prev_ireq   = 1'b0;
        CLK         = 1'b0;
        nRST        = 1'b0;
        load_expected();
        repeat (3) @(posedge CLK);
        #1 nRST = 1'b1;
        cycles = 0;
        while (!halt && cycles < 4000) begin
            @(posedge CLK);
            cycles++;
        end
        if (!halt) begin
            errors++;
            $display("Timed out waiting for halt after %0d cycles", cycles);
        end
        // Watch window for activity after halt
        repeat (20) @(posedge CLK);
        if (exp_addr.size() != 0) begin
            errors++;
            $display("%0d expected stores never happened", exp_addr.size());
        end
        check_value("mal_access pulses", mal_count, 32'd2);
        $display("Errors: %0d, stores seen: %0d", errors, store_count);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule
